/* kalman_pkg.sv */
package kalman_pkg;

	localparam int HARMONICS_NUM = 4;
	localparam int SERIES_NUM = 3;
	localparam int FRAC_BITS = 16;
	localparam int WORD_BITS = 18;

	localparam int STATE_ADDR_BITS = 6;
	localparam int COEF_ADDR_BITS = 5;

	// State memory holds one block per series
	localparam int STATE_SERIES_STRIDE = 16;
	localparam int STATE_SLOTS = 3;
	localparam int STATE_COMMON_BASE = 12;

	// Coefficients are shared by all series, inputs follow the harmonic table
	localparam int COEF_SLOTS = 4;
	localparam int COEF_INPUT_BASE = 16;

	// Address generator roles
	localparam int ROLE_STATE_A = 0;
	localparam int ROLE_STATE_B = 1;
	localparam int ROLE_COEF = 2;

	typedef logic signed [WORD_BITS-1:0] word_t;
	typedef logic [STATE_ADDR_BITS-1:0] state_addr_t;
	typedef logic [COEF_ADDR_BITS-1:0] coef_addr_t;
	typedef logic [1:0] harm_idx_t;
	typedef logic [1:0] series_idx_t;

	typedef enum logic [3:0] {
		SLOT_X1,
		SLOT_X2,
		SLOT_AMP,
		SLOT_SUM,
		SLOT_ERR,
		SLOT_COS,
		SLOT_SIN,
		SLOT_K1,
		SLOT_K2,
		SLOT_INP
	} slot_e;

	typedef enum logic [2:0] {
		OP_NOP,
		OP_ROT_X1,
		OP_ROT_X2,
		OP_CLR_SUM,
		OP_ERR,
		OP_AMP,
		OP_COR_X1,
		OP_COR_X2
	} op_e;

	typedef struct packed {
		op_e op;
		harm_idx_t harm;
		series_idx_t series;
	} micro_op_t;

	typedef struct packed {
		logic valid;
		state_addr_t addr;
		word_t data;
	} state_wr_t;

	// mem_sel high selects the coefficient memory
	typedef struct packed {
		logic valid;
		logic mem_sel;
		state_addr_t addr;
		word_t data;
	} host_wr_t;

	// Offset of a per-harmonic word within its harmonic record
	function automatic int slot_offset(slot_e slot);
		case (slot)
			SLOT_X2, SLOT_SIN: return 1;
			SLOT_AMP, SLOT_K1: return 2;
			SLOT_K2: return 3;
			default: return 0;
		endcase
	endfunction

endpackage

/* kalman_ram.sv */
`timescale 1ns/1ps

module kalman_ram #(
	parameter int ADDR_BITS = 6
) (
	input logic clk_i,
	input logic we_i,
	input logic [ADDR_BITS-1:0] waddr_i,
	input kalman_pkg::word_t wdata_i,
	input logic [ADDR_BITS-1:0] raddr_i,
	output kalman_pkg::word_t rdata_o
);
	import kalman_pkg::*;

	word_t mem [2**ADDR_BITS];

	// Read returns the old word when both ports hit the same address
	always_ff @(posedge clk_i) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
		rdata_o <= mem[raddr_i];
	end

endmodule

/* kalman_addr_gen.sv */
`timescale 1ns/1ps

module kalman_addr_gen #(
	parameter int SLOTS = 3,
	parameter int SERIES_STRIDE = 16,
	parameter int ADDR_BITS = 6,
	parameter int ROLE = 0
) (
	input logic clk_i,
	input kalman_pkg::micro_op_t op_i,
	input kalman_pkg::slot_e slot_i,
	output logic [ADDR_BITS-1:0] addr_o
);
	import kalman_pkg::*;

	slot_e slot;
	int unsigned base;
	int unsigned addr_next;

	// slot_i is the word read when the op leaves this port unused
	always_comb begin
		slot = slot_i;
		case (ROLE)
			ROLE_STATE_A: begin
				case (op_i.op)
					OP_ROT_X1, OP_AMP, OP_COR_X1: slot = SLOT_X1;
					OP_ROT_X2, OP_COR_X2: slot = SLOT_X2;
					OP_CLR_SUM: slot = SLOT_SUM;
					OP_ERR: slot = SLOT_ERR;
					default: slot = slot_i;
				endcase
			end
			ROLE_STATE_B: begin
				case (op_i.op)
					OP_ROT_X1, OP_AMP: slot = SLOT_X2;
					OP_ROT_X2: slot = SLOT_X1;
					default: slot = slot_i;
				endcase
			end
			default: begin
				case (op_i.op)
					OP_ROT_X1: slot = SLOT_COS;
					OP_ROT_X2: slot = SLOT_SIN;
					OP_ERR: slot = SLOT_INP;
					OP_COR_X1: slot = SLOT_K1;
					OP_COR_X2: slot = SLOT_K2;
					default: slot = slot_i;
				endcase
			end
		endcase
	end

	always_comb begin
		case (slot)
			SLOT_SUM: base = STATE_COMMON_BASE;
			SLOT_ERR: base = STATE_COMMON_BASE + 1;
			SLOT_INP: base = COEF_INPUT_BASE + int'(op_i.series);
			default: base = int'(op_i.harm) * SLOTS + slot_offset(slot);
		endcase
		addr_next = base + int'(op_i.series) * SERIES_STRIDE;
	end

	always_ff @(posedge clk_i) begin
		addr_o <= addr_next[ADDR_BITS-1:0];
	end

endmodule

/* kalman_sequencer.sv */
`timescale 1ns/1ps

module kalman_sequencer (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	output kalman_pkg::micro_op_t op_o,
	output logic busy_o
);
	import kalman_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ROTATE,
		ST_ERROR,
		ST_CORRECT,
		ST_DRAIN
	} state_e;

	state_e state_q;
	logic [1:0] step_q;
	harm_idx_t harm_q;
	series_idx_t series_q;
	logic harm_last;
	logic series_last;

	assign harm_last = harm_q == harm_idx_t'(HARMONICS_NUM - 1);
	assign series_last = series_q == series_idx_t'(SERIES_NUM - 1);
	assign busy_o = state_q != ST_IDLE;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= ST_IDLE;
			step_q <= '0;
			harm_q <= '0;
			series_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					step_q <= '0;
					harm_q <= '0;
					series_q <= '0;
					if (start_i)
						state_q <= ST_ROTATE;
				end
				ST_ROTATE: begin
					if (step_q == 2'd2) begin
						step_q <= '0;
						if (harm_last) begin
							harm_q <= '0;
							state_q <= ST_ERROR;
						end else begin
							harm_q <= harm_q + 1'b1;
						end
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				ST_ERROR: begin
					if (step_q == 2'd1) begin
						step_q <= '0;
						state_q <= ST_CORRECT;
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				ST_CORRECT: begin
					if (step_q == 2'd2) begin
						step_q <= '0;
						if (harm_last) begin
							harm_q <= '0;
							if (series_last) begin
								state_q <= ST_DRAIN;
							end else begin
								series_q <= series_q + 1'b1;
								state_q <= ST_ROTATE;
							end
						end else begin
							harm_q <= harm_q + 1'b1;
						end
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				default: begin
					// Three idle cycles let the last write-backs leave the MAC
					if (step_q == 2'd2) begin
						step_q <= '0;
						state_q <= ST_IDLE;
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
			endcase
		end
	end

	// Step 0 of each rotation is a NOP so the sine can be fetched ahead of the cosine
	always_comb begin
		op_o.op = OP_NOP;
		op_o.harm = harm_q;
		op_o.series = series_q;
		case (state_q)
			ST_ROTATE: begin
				if (step_q == 2'd1)
					op_o.op = OP_ROT_X1;
				else if (step_q == 2'd2)
					op_o.op = OP_ROT_X2;
			end
			ST_ERROR: begin
				op_o.op = (step_q == 2'd0) ? OP_ERR : OP_CLR_SUM;
			end
			ST_CORRECT: begin
				if (step_q == 2'd0)
					op_o.op = OP_AMP;
				else if (step_q == 2'd1)
					op_o.op = OP_COR_X1;
				else
					op_o.op = OP_COR_X2;
			end
			default: op_o.op = OP_NOP;
		endcase
	end

endmodule

/* kalman_mac.sv */
`timescale 1ns/1ps

module kalman_mac (
	input logic clk_i,
	input logic harmonics_rst,
	input kalman_pkg::micro_op_t op_i,
	input kalman_pkg::word_t state_a_i,
	input kalman_pkg::word_t state_b_i,
	input kalman_pkg::word_t coef_i,
	input kalman_pkg::state_addr_t waddr_i,
	output kalman_pkg::state_wr_t state_wr_o
);
	import kalman_pkg::*;

	micro_op_t op_d1;
	micro_op_t op_d2;
	state_addr_t waddr_q;
	state_addr_t waddr;
	word_t coef_q;
	word_t sum_q;
	word_t err_q;
	word_t result;

	function automatic word_t mul_q(word_t a, word_t b);
		logic signed [2*WORD_BITS-1:0] p;
		p = a * b;
		return word_t'(p >>> FRAC_BITS);
	endfunction

	// coef_q holds the word fetched one cycle earlier, the sine for ROT_X1 and
	// the cosine for ROT_X2
	always_comb begin
		case (op_d2.op)
			OP_ROT_X1: result = mul_q(coef_i, state_a_i) - mul_q(coef_q, state_b_i);
			OP_ROT_X2: result = mul_q(coef_i, state_b_i) + mul_q(coef_q, state_a_i);
			OP_CLR_SUM: result = sum_q;
			OP_ERR: result = coef_i - sum_q;
			OP_AMP: result = mul_q(state_a_i, state_a_i) + mul_q(state_b_i, state_b_i);
			OP_COR_X1, OP_COR_X2: result = state_a_i + mul_q(coef_i, err_q);
			default: result = '0;
		endcase
	end

	// The A port points at x1 for AMP, so step over to the amplitude word
	assign waddr = (op_d2.op == OP_AMP) ?
		waddr_q + state_addr_t'(slot_offset(SLOT_AMP)) : waddr_q;

	always_ff @(posedge clk_i) begin
		waddr_q <= waddr_i;
		coef_q <= coef_i;
		state_wr_o.addr <= waddr;
		state_wr_o.data <= result;
		if (op_d2.op == OP_ERR)
			err_q <= result;
		if (harmonics_rst) begin
			op_d1 <= '0;
			op_d2 <= '0;
			state_wr_o.valid <= 1'b0;
			sum_q <= '0;
		end else begin
			op_d1 <= op_i;
			op_d2 <= op_d1;
			state_wr_o.valid <= op_d2.op != OP_NOP;
			// CLR_SUM stores the finished sum and starts the next series from zero
			if (op_d2.op == OP_ROT_X1)
				sum_q <= sum_q + result;
			else if (op_d2.op == OP_CLR_SUM)
				sum_q <= '0;
		end
	end

endmodule

/* kalman_top.sv */
`timescale 1ns/1ps

module kalman_top (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input kalman_pkg::host_wr_t host_wr_i,
	output logic busy_o,
	output kalman_pkg::state_wr_t state_wr_o
);
	import kalman_pkg::*;

	micro_op_t op;
	state_addr_t state_raddr_a;
	state_addr_t state_raddr_b;
	coef_addr_t coef_raddr;
	word_t state_a;
	word_t state_b;
	word_t coef;
	state_wr_t mac_wr;

	logic state_we;
	state_addr_t state_waddr;
	word_t state_wdata;
	logic coef_we;

	kalman_sequencer u_sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_i(start_i),
		.op_o(op),
		.busy_o(busy_o)
	);

	kalman_addr_gen #(
		.SLOTS(STATE_SLOTS),
		.SERIES_STRIDE(STATE_SERIES_STRIDE),
		.ADDR_BITS(STATE_ADDR_BITS),
		.ROLE(ROLE_STATE_A)
	) u_addr_state_a (
		.clk_i(clk_i),
		.op_i(op),
		.slot_i(SLOT_X1),
		.addr_o(state_raddr_a)
	);

	kalman_addr_gen #(
		.SLOTS(STATE_SLOTS),
		.SERIES_STRIDE(STATE_SERIES_STRIDE),
		.ADDR_BITS(STATE_ADDR_BITS),
		.ROLE(ROLE_STATE_B)
	) u_addr_state_b (
		.clk_i(clk_i),
		.op_i(op),
		.slot_i(SLOT_X2),
		.addr_o(state_raddr_b)
	);

	// Coefficients are common to all series
	kalman_addr_gen #(
		.SLOTS(COEF_SLOTS),
		.SERIES_STRIDE(0),
		.ADDR_BITS(COEF_ADDR_BITS),
		.ROLE(ROLE_COEF)
	) u_addr_coef (
		.clk_i(clk_i),
		.op_i(op),
		.slot_i(SLOT_SIN),
		.addr_o(coef_raddr)
	);

	// The engine owns the state write port during a run, host writes are dropped
	assign state_we = busy_o ? mac_wr.valid : (host_wr_i.valid && !host_wr_i.mem_sel);
	assign state_waddr = busy_o ? mac_wr.addr : host_wr_i.addr;
	assign state_wdata = busy_o ? mac_wr.data : host_wr_i.data;
	assign coef_we = !busy_o && host_wr_i.valid && host_wr_i.mem_sel;

	kalman_ram #(.ADDR_BITS(STATE_ADDR_BITS)) u_state_ram_a (
		.clk_i(clk_i),
		.we_i(state_we),
		.waddr_i(state_waddr),
		.wdata_i(state_wdata),
		.raddr_i(state_raddr_a),
		.rdata_o(state_a)
	);

	kalman_ram #(.ADDR_BITS(STATE_ADDR_BITS)) u_state_ram_b (
		.clk_i(clk_i),
		.we_i(state_we),
		.waddr_i(state_waddr),
		.wdata_i(state_wdata),
		.raddr_i(state_raddr_b),
		.rdata_o(state_b)
	);

	kalman_ram #(.ADDR_BITS(COEF_ADDR_BITS)) u_coef_ram (
		.clk_i(clk_i),
		.we_i(coef_we),
		.waddr_i(host_wr_i.addr[COEF_ADDR_BITS-1:0]),
		.wdata_i(host_wr_i.data),
		.raddr_i(coef_raddr),
		.rdata_o(coef)
	);

	kalman_mac u_mac (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.op_i(op),
		.state_a_i(state_a),
		.state_b_i(state_b),
		.coef_i(coef),
		.waddr_i(state_raddr_a),
		.state_wr_o(mac_wr)
	);

	assign state_wr_o = mac_wr;

endmodule

/* tb_kalman_checker.sv */
`timescale 1ns/1ps

module tb_kalman_checker (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input kalman_pkg::host_wr_t host_wr_i,
	input logic busy_i,
	input kalman_pkg::state_wr_t state_wr_i,
	output int mismatch_count_o,
	output int other_count_o,
	output int pending_o
);
	import kalman_pkg::*;

	word_t state_mem [2**STATE_ADDR_BITS];
	word_t coef_mem [2**COEF_ADDR_BITS];
	state_addr_t exp_addr [$];
	word_t exp_data [$];
	logic run_active;

	initial begin
		mismatch_count_o = 0;
		other_count_o = 0;
		pending_o = 0;
		run_active = 1'b0;
	end

	// Q16 product, floored by the arithmetic shift and wrapped to one word
	function automatic word_t fx_mul(word_t a, word_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return word_t'(p >>> FRAC_BITS);
	endfunction

	function automatic void expect_write(int addr, word_t data);
		exp_addr.push_back(state_addr_t'(addr));
		exp_data.push_back(data);
		state_mem[addr] = data;
	endfunction

	// Runs every series through rotation, error and correction on the shadow memories
	function automatic void run_model();
		int base;
		int rec;
		word_t x1;
		word_t x2;
		word_t cs;
		word_t sn;
		word_t rot;
		word_t sum;
		word_t err;
		for (int s = 0; s < SERIES_NUM; s++) begin
			base = s * STATE_SERIES_STRIDE;
			sum = '0;
			for (int h = 0; h < HARMONICS_NUM; h++) begin
				rec = base + h * STATE_SLOTS;
				x1 = state_mem[rec];
				x2 = state_mem[rec + 1];
				cs = coef_mem[h * COEF_SLOTS];
				sn = coef_mem[h * COEF_SLOTS + 1];
				rot = fx_mul(cs, x1) - fx_mul(sn, x2);
				expect_write(rec, rot);
				expect_write(rec + 1, fx_mul(sn, x1) + fx_mul(cs, x2));
				sum = sum + rot;
			end
			err = coef_mem[COEF_INPUT_BASE + s] - sum;
			expect_write(base + STATE_COMMON_BASE + 1, err);
			expect_write(base + STATE_COMMON_BASE, sum);
			for (int h = 0; h < HARMONICS_NUM; h++) begin
				rec = base + h * STATE_SLOTS;
				x1 = state_mem[rec];
				x2 = state_mem[rec + 1];
				expect_write(rec + 2, fx_mul(x1, x1) + fx_mul(x2, x2));
				expect_write(rec, x1 + fx_mul(coef_mem[h * COEF_SLOTS + 2], err));
				expect_write(rec + 1, x2 + fx_mul(coef_mem[h * COEF_SLOTS + 3], err));
			end
		end
	endfunction

	task automatic compare_write();
		state_addr_t addr;
		word_t data;
		if (exp_addr.size() == 0) begin
			$display("unexpected state write to address %h while no write was due",
				state_wr_i.addr);
			other_count_o++;
		end else begin
			addr = exp_addr.pop_front();
			data = exp_data.pop_front();
			if (state_wr_i.addr !== addr) begin
				$display("mismatch state_wr_o.addr: expected %h, got %h", addr, state_wr_i.addr);
				mismatch_count_o++;
			end
			if (state_wr_i.data !== data) begin
				$display("mismatch state_wr_o.data at %h: expected %h, got %h",
					addr, data, state_wr_i.data);
				mismatch_count_o++;
			end
		end
	endtask

	// Sampled mid-cycle, where every DUT output and every driven input is settled
	always @(negedge clk_i) begin
		if (harmonics_rst) begin
			run_active = 1'b0;
		end else begin
			if (state_wr_i.valid === 1'b1) begin
				compare_write();
			end else if (state_wr_i.valid !== 1'b0) begin
				$display("state_wr_o.valid is unknown");
				other_count_o++;
			end
			if (!run_active && busy_i !== 1'b0) begin
				$display("busy_o is not low although no run was started");
				other_count_o++;
			end
			if (run_active && busy_i === 1'b0) begin
				if (exp_addr.size() != 0) begin
					$display("run ended with %0d expected state writes missing", exp_addr.size());
					other_count_o++;
				end
				exp_addr.delete();
				exp_data.delete();
				run_active = 1'b0;
			end
			if (host_wr_i.valid && busy_i === 1'b0) begin
				if (host_wr_i.mem_sel)
					coef_mem[host_wr_i.addr[COEF_ADDR_BITS-1:0]] = host_wr_i.data;
				else
					state_mem[host_wr_i.addr] = host_wr_i.data;
			end
			if (start_i && busy_i === 1'b0) begin
				run_model();
				run_active = 1'b1;
			end
		end
		pending_o = exp_addr.size();
	end

endmodule

/* tb_kalman.sv */
`timescale 1ns/1ps

module tb_kalman;
	import kalman_pkg::*;

	localparam int WAIT_LIMIT = 400;
	localparam word_t FX_ONE = word_t'(1 << FRAC_BITS);

	// Coefficient sets for load_coefs
	localparam int COEF_RANDOM = 0;
	localparam int COEF_IDENTITY = 1;
	localparam int COEF_NO_GAIN = 2;

	logic clk;
	logic harmonics_rst;
	logic start;
	host_wr_t host_wr;
	logic busy;
	state_wr_t state_wr;
	int mismatch_count;
	int other_count;
	int pending;
	int tb_errors;

	kalman_top dut_i (
		.clk_i(clk),
		.harmonics_rst(harmonics_rst),
		.start_i(start),
		.host_wr_i(host_wr),
		.busy_o(busy),
		.state_wr_o(state_wr)
	);

	tb_kalman_checker u_checker (
		.clk_i(clk),
		.harmonics_rst(harmonics_rst),
		.start_i(start),
		.host_wr_i(host_wr),
		.busy_i(busy),
		.state_wr_i(state_wr),
		.mismatch_count_o(mismatch_count),
		.other_count_o(other_count),
		.pending_o(pending)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic finish_run();
		int others;
		others = other_count + tb_errors;
		if (pending != 0) begin
			$display("%0d expected state writes never appeared", pending);
			others++;
		end
		$display("errors: mismatches=%0d other=%0d", mismatch_count, others);
		if (mismatch_count == 0 && others == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	task automatic host_write(logic sel, int addr, word_t data);
		host_wr.valid = 1'b1;
		host_wr.mem_sel = sel;
		host_wr.addr = state_addr_t'(addr);
		host_wr.data = data;
		next_cycle();
		host_wr.valid = 1'b0;
	endtask

	task automatic wait_busy(logic level);
		int n;
		n = 0;
		while (busy !== level && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (busy !== level) begin
			$display("timeout: busy_o did not go %s within %0d cycles",
				level ? "high" : "low", WAIT_LIMIT);
			tb_errors++;
			finish_run();
		end
	endtask

	task automatic load_states();
		for (int a = 0; a < 2**STATE_ADDR_BITS; a++)
			host_write(1'b0, a, word_t'($urandom));
	endtask

	task automatic load_coefs(int kind);
		word_t cs;
		word_t sn;
		word_t k1;
		word_t k2;
		for (int h = 0; h < HARMONICS_NUM; h++) begin
			// Any 18-bit Q16 value already lies within plus or minus two
			cs = word_t'($urandom);
			sn = word_t'($urandom);
			k1 = word_t'($urandom);
			k2 = word_t'($urandom);
			if (kind == COEF_IDENTITY) begin
				cs = FX_ONE;
				sn = '0;
			end
			if (kind != COEF_RANDOM) begin
				k1 = '0;
				k2 = '0;
			end
			host_write(1'b1, h * COEF_SLOTS, cs);
			host_write(1'b1, h * COEF_SLOTS + 1, sn);
			host_write(1'b1, h * COEF_SLOTS + 2, k1);
			host_write(1'b1, h * COEF_SLOTS + 3, k2);
		end
		for (int s = 0; s < SERIES_NUM; s++)
			host_write(1'b1, COEF_INPUT_BASE + s, word_t'($urandom));
	endtask

	// With busy_hits set, random host writes are thrown at the DUT during the run
	task automatic run_once(int busy_hits);
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		wait_busy(1'b1);
		repeat (busy_hits)
			host_write(logic'($urandom % 2), $urandom % 64, word_t'($urandom));
		wait_busy(1'b0);
		repeat (2)
			next_cycle();
	endtask

	initial begin
		void'($urandom(32'h9a19_942c));
		tb_errors = 0;
		harmonics_rst = 1'b1;
		start = 1'b0;
		host_wr = '0;
		repeat (16)
			@(posedge clk);
		#1;
		harmonics_rst = 1'b0;
		repeat (8)
			next_cycle();

		load_states();
		load_coefs(COEF_RANDOM);
		run_once(0);
		run_once(0);

		run_once(24);
		run_once(0);

		load_coefs(COEF_IDENTITY);
		run_once(0);
		load_coefs(COEF_NO_GAIN);
		run_once(0);

		repeat (8)
			next_cycle();
		finish_run();
	end

endmodule

/* build.f */
kalman_pkg.sv
kalman_ram.sv
kalman_addr_gen.sv
kalman_sequencer.sv
kalman_mac.sv
kalman_top.sv
tb_kalman_checker.sv
tb_kalman.sv

/* Bender.yml */
package:
  name: kalman_tracker

sources:
  - kalman_pkg.sv
  - kalman_ram.sv
  - kalman_addr_gen.sv
  - kalman_sequencer.sv
  - kalman_mac.sv
  - kalman_top.sv
  - target: test
    files:
      - tb_kalman_checker.sv
      - tb_kalman.sv
